//--- Bender.yml
package:
  name: axi_mem_pipe

export_include_dirs:
  - include

sources:
  - hdl/axi_mem_pkg.sv
  - hdl/axi_mem_if.sv
  - hdl/ready_enable_skid.sv
  - hdl/axi_mem_reg.sv
  - hdl/mem_ctrl.sv
  - hdl/mem_array.sv
  - hdl/axi_mem_pipe_top.sv
  - target: test
    files:
      - testbench/axi_mem_pipe_tb.sv

//--- axi_mem_pipe.f
+incdir+include
hdl/axi_mem_pkg.sv
hdl/axi_mem_if.sv
hdl/ready_enable_skid.sv
hdl/axi_mem_reg.sv
hdl/mem_ctrl.sv
hdl/mem_array.sv
hdl/axi_mem_pipe_top.sv
testbench/axi_mem_pipe_tb.sv

//--- hdl/axi_mem_if.sv
// Five-channel AXI memory port with single-beat transfers and IDs
`timescale 1ns/1ps
`default_nettype none

interface axi_mem_if
(
    input logic clk,
    input logic rst_n
);
    import axi_mem_pkg::*;

    // Write address
    logic     awvalid;
    logic     awready;
    aw_beat_t aw;

    // Write data
    logic     wvalid;
    logic     wready;
    w_beat_t  w;

    // Write response
    logic     bvalid;
    logic     bready;
    b_beat_t  b;

    // Read address
    logic     arvalid;
    logic     arready;
    ar_beat_t ar;

    // Read data
    logic     rvalid;
    logic     rready;
    r_beat_t  r;

    modport master
    (
        input  clk, rst_n,
        output awvalid, aw, wvalid, w, arvalid, ar, bready, rready,
        input  awready, wready, arready, bvalid, b, rvalid, r
    );

    modport slave
    (
        input  clk, rst_n,
        input  awvalid, aw, wvalid, w, arvalid, ar, bready, rready,
        output awready, wready, arready, bvalid, b, rvalid, r
    );

endinterface

`default_nettype wire

//--- hdl/axi_mem_pipe_top.sv
// Top level joining plain AXI ports, the register pipeline and the memory
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

module axi_mem_pipe_top
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic                awvalid,
    output logic                awready,
    input  axi_mem_pkg::id_t    awid,
    input  axi_mem_pkg::addr_t  awaddr,

    input  logic                wvalid,
    output logic                wready,
    input  axi_mem_pkg::data_t  wdata,
    input  axi_mem_pkg::strb_t  wstrb,

    output logic                bvalid,
    input  logic                bready,
    output axi_mem_pkg::id_t    bid,
    output axi_mem_pkg::resp_t  bresp,

    input  logic                arvalid,
    output logic                arready,
    input  axi_mem_pkg::id_t    arid,
    input  axi_mem_pkg::addr_t  araddr,

    output logic                rvalid,
    input  logic                rready,
    output axi_mem_pkg::id_t    rid,
    output axi_mem_pkg::data_t  rdata,
    output axi_mem_pkg::resp_t  rresp
);
    import axi_mem_pkg::*;

    logic      wr_en;
    word_idx_t wr_idx;
    data_t     wr_data;
    strb_t     wr_strb;
    logic      rd_en;
    word_idx_t rd_idx;
    data_t     rd_data;

    axi_mem_if m_side (.clk(clk), .rst_n(rst_n));
    axi_mem_if s_side (.clk(clk), .rst_n(rst_n));

    // Pack the plain ports into channel beats
    assign m_side.awvalid = awvalid;
    assign m_side.aw      = '{id: awid, addr: awaddr};
    assign m_side.wvalid  = wvalid;
    assign m_side.w       = '{data: wdata, strb: wstrb};
    assign m_side.arvalid = arvalid;
    assign m_side.ar      = '{id: arid, addr: araddr};
    assign m_side.bready  = bready;
    assign m_side.rready  = rready;

    assign awready = m_side.awready;
    assign wready  = m_side.wready;
    assign arready = m_side.arready;
    assign bvalid  = m_side.bvalid;
    assign bid     = m_side.b.id;
    assign bresp   = m_side.b.resp;
    assign rvalid  = m_side.rvalid;
    assign rid     = m_side.r.id;
    assign rdata   = m_side.r.data;
    assign rresp   = m_side.r.resp;

    axi_mem_reg #(.N_REG_STAGES(`MEM_REG_STAGES)) u_reg
    (
        .mem_master(m_side.slave),
        .mem_slave(s_side.master)
    );

    mem_ctrl u_ctrl
    (
        .mem(s_side.slave),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

    mem_array u_array
    (
        .clk(clk),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- hdl/axi_mem_pkg.sv
// Shared vector types, channel beats, response codes and controller states
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

package axi_mem_pkg;

    typedef logic [`AXI_ADDR_W-1:0]       addr_t;
    typedef logic [`AXI_DATA_W-1:0]       data_t;
    typedef logic [`AXI_DATA_W/8-1:0]     strb_t;
    typedef logic [`AXI_ID_W-1:0]         id_t;
    typedef logic [1:0]                   resp_t;
    typedef logic [`MEM_WORDS_LOG2-1:0]   word_idx_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Address channels share one layout
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } aw_beat_t;

    typedef struct packed {
        id_t   id;
        addr_t addr;
    } ar_beat_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_beat_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_beat_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
    } r_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ,
        READ_DATA,
        RESP
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/axi_mem_reg.sv
// Configurable chain of skid stages on all five AXI memory channels
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

module axi_mem_reg
#(
    parameter int N_REG_STAGES = `MEM_REG_STAGES
)
(
    axi_mem_if.slave  mem_master,
    axi_mem_if.master mem_slave
);
    import axi_mem_pkg::*;

    // Element 0 faces the traffic source, element N_REG_STAGES the memory.
    // With no stages both ends are the same element and the path is wires.
    axi_mem_if pipe[N_REG_STAGES+1] (.clk(mem_master.clk), .rst_n(mem_master.rst_n));

    assign pipe[0].awvalid          = mem_master.awvalid;
    assign pipe[0].aw               = mem_master.aw;
    assign pipe[0].wvalid           = mem_master.wvalid;
    assign pipe[0].w                = mem_master.w;
    assign pipe[0].arvalid          = mem_master.arvalid;
    assign pipe[0].ar               = mem_master.ar;
    assign pipe[0].bready           = mem_master.bready;
    assign pipe[0].rready           = mem_master.rready;
    assign mem_master.awready       = pipe[0].awready;
    assign mem_master.wready        = pipe[0].wready;
    assign mem_master.arready       = pipe[0].arready;
    assign mem_master.bvalid        = pipe[0].bvalid;
    assign mem_master.b             = pipe[0].b;
    assign mem_master.rvalid        = pipe[0].rvalid;
    assign mem_master.r             = pipe[0].r;

    assign mem_slave.awvalid        = pipe[N_REG_STAGES].awvalid;
    assign mem_slave.aw             = pipe[N_REG_STAGES].aw;
    assign mem_slave.wvalid         = pipe[N_REG_STAGES].wvalid;
    assign mem_slave.w              = pipe[N_REG_STAGES].w;
    assign mem_slave.arvalid        = pipe[N_REG_STAGES].arvalid;
    assign mem_slave.ar             = pipe[N_REG_STAGES].ar;
    assign mem_slave.bready         = pipe[N_REG_STAGES].bready;
    assign mem_slave.rready         = pipe[N_REG_STAGES].rready;
    assign pipe[N_REG_STAGES].awready = mem_slave.awready;
    assign pipe[N_REG_STAGES].wready  = mem_slave.wready;
    assign pipe[N_REG_STAGES].arready = mem_slave.arready;
    assign pipe[N_REG_STAGES].bvalid  = mem_slave.bvalid;
    assign pipe[N_REG_STAGES].b       = mem_slave.b;
    assign pipe[N_REG_STAGES].rvalid  = mem_slave.rvalid;
    assign pipe[N_REG_STAGES].r       = mem_slave.r;

    genvar s;
    generate
        for (s = 1; s <= N_REG_STAGES; s = s + 1)
        begin : stage
            // Requests move toward the memory
            ready_enable_skid #(.WIDTH($bits(aw_beat_t))) aw_skid
            (
                .clk(pipe[s].clk), .rst_n(pipe[s].rst_n),
                .enable_from_src(pipe[s-1].awvalid), .data_from_src(pipe[s-1].aw),
                .ready_to_src(pipe[s-1].awready),
                .enable_to_dst(pipe[s].awvalid), .data_to_dst(pipe[s].aw),
                .ready_from_dst(pipe[s].awready)
            );

            ready_enable_skid #(.WIDTH($bits(w_beat_t))) w_skid
            (
                .clk(pipe[s].clk), .rst_n(pipe[s].rst_n),
                .enable_from_src(pipe[s-1].wvalid), .data_from_src(pipe[s-1].w),
                .ready_to_src(pipe[s-1].wready),
                .enable_to_dst(pipe[s].wvalid), .data_to_dst(pipe[s].w),
                .ready_from_dst(pipe[s].wready)
            );

            ready_enable_skid #(.WIDTH($bits(ar_beat_t))) ar_skid
            (
                .clk(pipe[s].clk), .rst_n(pipe[s].rst_n),
                .enable_from_src(pipe[s-1].arvalid), .data_from_src(pipe[s-1].ar),
                .ready_to_src(pipe[s-1].arready),
                .enable_to_dst(pipe[s].arvalid), .data_to_dst(pipe[s].ar),
                .ready_from_dst(pipe[s].arready)
            );

            // Responses move back toward the source
            ready_enable_skid #(.WIDTH($bits(b_beat_t))) b_skid
            (
                .clk(pipe[s].clk), .rst_n(pipe[s].rst_n),
                .enable_from_src(pipe[s].bvalid), .data_from_src(pipe[s].b),
                .ready_to_src(pipe[s].bready),
                .enable_to_dst(pipe[s-1].bvalid), .data_to_dst(pipe[s-1].b),
                .ready_from_dst(pipe[s-1].bready)
            );

            ready_enable_skid #(.WIDTH($bits(r_beat_t))) r_skid
            (
                .clk(pipe[s].clk), .rst_n(pipe[s].rst_n),
                .enable_from_src(pipe[s].rvalid), .data_from_src(pipe[s].r),
                .ready_to_src(pipe[s].rready),
                .enable_to_dst(pipe[s-1].rvalid), .data_to_dst(pipe[s-1].r),
                .ready_from_dst(pipe[s-1].rready)
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- hdl/mem_array.sv
// Word memory with byte-strobe writes and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

module mem_array
(
    input  logic                    clk,
    input  logic                    wr_en,
    input  axi_mem_pkg::word_idx_t  wr_idx,
    input  axi_mem_pkg::data_t      wr_data,
    input  axi_mem_pkg::strb_t      wr_strb,
    input  logic                    rd_en,
    input  axi_mem_pkg::word_idx_t  rd_idx,
    output axi_mem_pkg::data_t      rd_data
);
    import axi_mem_pkg::*;

    data_t mem [2**`MEM_WORDS_LOG2];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int i = 0; i < $bits(strb_t); i++)
            begin
                if (wr_strb[i])
                begin
                    mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
        if (rd_en)
        begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_ctrl.sv
// Memory controller that serves single-beat AXI reads and writes in order
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

module mem_ctrl
(
    axi_mem_if.slave                mem,

    output logic                    wr_en,
    output axi_mem_pkg::word_idx_t  wr_idx,
    output axi_mem_pkg::data_t      wr_data,
    output axi_mem_pkg::strb_t      wr_strb,

    output logic                    rd_en,
    output axi_mem_pkg::word_idx_t  rd_idx,
    input  axi_mem_pkg::data_t      rd_data
);
    import axi_mem_pkg::*;

    localparam int IDX_LSB = $clog2($bits(strb_t));
    localparam int IDX_MSB = IDX_LSB + `MEM_WORDS_LOG2 - 1;

    ctrl_state_t state;
    logic        last_rd;
    logic        take_wr;
    logic        take_rd;
    logic        aw_ok;
    logic        ar_ok;
    logic        req_ok;
    word_idx_t   req_idx;
    data_t       req_data;
    strb_t       req_strb;
    b_beat_t     b_q;
    id_t         r_id;
    resp_t       r_resp;
    data_t       r_data;

    function automatic logic addr_in_range(addr_t addr);
        return (addr >> (IDX_MSB + 1)) == '0;
    endfunction

    assign aw_ok = addr_in_range(mem.aw.addr);
    assign ar_ok = addr_in_range(mem.ar.addr);

    // Writes need both halves; when both kinds wait, the one not served last wins
    assign take_wr = (state == IDLE) && mem.awvalid && mem.wvalid && (!mem.arvalid || last_rd);
    assign take_rd = (state == IDLE) && mem.arvalid && !take_wr;

    assign mem.awready = take_wr;
    assign mem.wready  = take_wr;
    assign mem.arready = take_rd;

    // Out-of-range reads never touch the array and return zero
    assign r_data = req_ok ? rd_data : '0;

    // In RESP, last_rd tells which response is waiting
    assign mem.bvalid = (state == WRITE) || ((state == RESP) && !last_rd);
    assign mem.rvalid = (state == READ_DATA) || ((state == RESP) && last_rd);
    assign mem.b      = b_q;
    assign mem.r      = '{id: r_id, data: r_data, resp: r_resp};

    assign wr_en   = (state == WRITE) && req_ok;
    assign wr_idx  = req_idx;
    assign wr_data = req_data;
    assign wr_strb = req_strb;
    assign rd_en   = (state == READ) && req_ok;
    assign rd_idx  = req_idx;

    always_ff @(posedge mem.clk or negedge mem.rst_n)
    begin
        if (!mem.rst_n)
        begin
            state   <= IDLE;
            last_rd <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (take_wr || take_rd)
                    begin
                        state   <= take_wr ? WRITE : READ;
                        last_rd <= take_rd;
                    end
                end
                // Array write happens here while b is offered
                WRITE:     state <= mem.bready ? IDLE : RESP;
                READ:      state <= READ_DATA;
                // Array word sits on rd_data here while r is offered
                READ_DATA: state <= mem.rready ? IDLE : RESP;
                RESP:
                begin
                    if (last_rd ? mem.rready : mem.bready)
                    begin
                        state <= IDLE;
                    end
                end
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge mem.clk)
    begin
        if (take_wr)
        begin
            req_ok    <= aw_ok;
            req_idx   <= mem.aw.addr[IDX_MSB:IDX_LSB];
            req_data  <= mem.w.data;
            req_strb  <= mem.w.strb;
            b_q.id    <= mem.aw.id;
            b_q.resp  <= aw_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (take_rd)
        begin
            req_ok    <= ar_ok;
            req_idx   <= mem.ar.addr[IDX_MSB:IDX_LSB];
            r_id      <= mem.ar.id;
            r_resp    <= ar_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ready_enable_skid.sv
// Single register stage for a ready/valid channel with a skid buffer
`timescale 1ns/1ps
`default_nettype none

module ready_enable_skid
#(
    parameter int WIDTH = 1
)
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic             enable_from_src,
    input  logic [WIDTH-1:0] data_from_src,
    output logic             ready_to_src,

    output logic             enable_to_dst,
    output logic [WIDTH-1:0] data_to_dst,
    input  logic             ready_from_dst
);

    logic             main_free;
    logic             src_xfer;
    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;

    // Main register can take a new beat when empty or draining
    assign main_free = !enable_to_dst || ready_from_dst;
    assign src_xfer  = enable_from_src && ready_to_src;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            enable_to_dst <= 1'b0;
            skid_valid    <= 1'b0;
            ready_to_src  <= 1'b0;
        end
        else if (main_free)
        begin
            // A parked beat goes first; ready was low while it was parked
            enable_to_dst <= skid_valid || src_xfer;
            skid_valid    <= 1'b0;
            ready_to_src  <= 1'b1;
        end
        else if (src_xfer)
        begin
            // Stalled with a beat arriving, so park it and close the input
            skid_valid    <= 1'b1;
            ready_to_src  <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            data_to_dst <= skid_valid ? skid_data : data_from_src;
        end
        else if (src_xfer)
        begin
            skid_data <= data_from_src;
        end
    end

endmodule

`default_nettype wire

//--- include/axi_mem_params_pkg_params.svh
// Width, memory depth and pipeline depth settings for the AXI memory pipeline
`ifndef AXI_MEM_PARAMS_PKG_PARAMS_SVH
`define AXI_MEM_PARAMS_PKG_PARAMS_SVH

// Byte address width
`define AXI_ADDR_W 16

// Data bus width, a whole number of bytes
`define AXI_DATA_W 32

// Transaction ID width
`define AXI_ID_W 4

// 1024 words of 32 bits, so 4 KiB of storage
`define MEM_WORDS_LOG2 10

// Skid stages per channel in the default build
`define MEM_REG_STAGES 2

`endif

//--- testbench/axi_mem_pipe_tb.sv
// Testbench for the AXI memory pipeline with a reference model and in-order response checks
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params_pkg_params.svh"

module axi_mem_pipe_tb;
    import axi_mem_pkg::*;

    // Under 900 transactions at well under 20 cycles each
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MEM_BYTES      = 4096;
    localparam int FILL_WORDS     = 64;
    localparam int READ_LATENCY   = 2 * `MEM_REG_STAGES + 2;

    logic    clk;
    logic    rst_n;
    logic    awvalid;
    logic    awready;
    id_t     awid;
    addr_t   awaddr;
    logic    wvalid;
    logic    wready;
    data_t   wdata;
    strb_t   wstrb;
    logic    bvalid;
    logic    bready;
    id_t     bid;
    resp_t   bresp;
    logic    arvalid;
    logic    arready;
    id_t     arid;
    addr_t   araddr;
    logic    rvalid;
    logic    rready;
    id_t     rid;
    data_t   rdata;
    resp_t   rresp;

    data_t   model_mem [int];
    b_beat_t exp_b [$];
    r_beat_t exp_r [$];
    int      cycle_cnt;
    int      ar_xfer_cycle;
    bit      first_ar_seen;
    bit      latency_checked;
    bit      stall_on;
    bit      b_stalled;
    bit      r_stalled;
    b_beat_t held_b;
    r_beat_t held_r;

    axi_mem_pipe_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            fail_run($sformatf("Timeout after %0d cycles with responses still missing",
                               cycle_cnt));
        end
    end

    // Response ready, random only during the stall phase
    initial
    begin
        bready = 1'b0;
        rready = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            bready = !stall_on || ($urandom_range(0, 4) < 3);
            rready = !stall_on || ($urandom_range(0, 4) < 3);
        end
    end

    // Expected write response from the memory image
    function automatic b_beat_t ref_write(id_t id, addr_t addr, data_t data, strb_t strb);
        b_beat_t b;
        data_t   word;
        int      idx;
        b.id   = id;
        b.resp = RESP_SLVERR;
        if (addr < MEM_BYTES)
        begin
            idx  = addr >> 2;
            word = model_mem.exists(idx) ? model_mem[idx] : '0;
            for (int i = 0; i < $bits(strb_t); i++)
            begin
                if (strb[i])
                    word[i*8 +: 8] = data[i*8 +: 8];
            end
            model_mem[idx] = word;
            b.resp = RESP_OKAY;
        end
        return b;
    endfunction

    function automatic r_beat_t ref_read(id_t id, addr_t addr);
        r_beat_t r;
        r.id   = id;
        r.data = '0;
        r.resp = RESP_SLVERR;
        if (addr < MEM_BYTES)
        begin
            r.resp = RESP_OKAY;
            if (model_mem.exists(int'(addr >> 2)))
                r.data = model_mem[int'(addr >> 2)];
        end
        return r;
    endfunction

    task automatic fail_run(string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_b(id_t got_id, resp_t got_resp, id_t exp_id, resp_t exp_resp);
        if (got_id !== exp_id)
            fail_run($sformatf("Fail at %0t: bid is %h, expected %h", $time, got_id, exp_id));
        else if (got_resp !== exp_resp)
            fail_run($sformatf("Fail at %0t: bresp is %h, expected %h", $time, got_resp,
                               exp_resp));
    endtask

    task automatic check_r(id_t got_id, data_t got_data, resp_t got_resp,
                           id_t exp_id, data_t exp_data, resp_t exp_resp);
        if (got_id !== exp_id)
            fail_run($sformatf("Fail at %0t: rid is %h, expected %h", $time, got_id, exp_id));
        else if (got_data !== exp_data)
            fail_run($sformatf("Fail at %0t: rdata is %h, expected %h", $time, got_data,
                               exp_data));
        else if (got_resp !== exp_resp)
            fail_run($sformatf("Fail at %0t: rresp is %h, expected %h", $time, got_resp,
                               exp_resp));
    endtask

    task automatic expect_cycles(string what, int got, int exp);
        if (got != exp)
            fail_run($sformatf("Fail at %0t: %s is %0d cycles, expected %0d", $time, what,
                               got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Called at the falling edge, where every handshake signal is settled
    task automatic watch_b();
        b_beat_t exp;
        if (b_stalled && (bvalid !== 1'b1 || bid !== held_b.id || bresp !== held_b.resp))
            fail_run("Write response dropped or changed while bready was low");
        b_stalled = 1'b0;
        if (bvalid === 1'b1 && bready)
        begin
            if (exp_b.size() == 0)
                fail_run("Write response arrived with no write outstanding");
            else
            begin
                exp = exp_b.pop_front();
                check_b(bid, bresp, exp.id, exp.resp);
            end
        end
        else if (bvalid === 1'b1)
        begin
            b_stalled = 1'b1;
            held_b    = '{id: bid, resp: bresp};
        end
    endtask

    task automatic watch_r();
        r_beat_t exp;
        r_beat_t now;
        now = '{id: rid, data: rdata, resp: rresp};
        if (r_stalled && (rvalid !== 1'b1 || now !== held_r))
            fail_run("Read response dropped or changed while rready was low");
        r_stalled = 1'b0;
        if (rvalid === 1'b1 && !latency_checked)
        begin
            expect_cycles("first read latency", cycle_cnt - ar_xfer_cycle, READ_LATENCY);
            latency_checked = 1'b1;
        end
        if (rvalid === 1'b1 && rready)
        begin
            if (exp_r.size() == 0)
                fail_run("Read response arrived with no read outstanding");
            else
            begin
                exp = exp_r.pop_front();
                check_r(rid, rdata, rresp, exp.id, exp.data, exp.resp);
            end
        end
        else if (rvalid === 1'b1)
        begin
            r_stalled = 1'b1;
            held_r    = now;
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (rst_n)
            begin
                watch_b();
                watch_r();
            end
        end
    end

    // Reads drain first so the model sees requests in the order the memory serves them
    task automatic issue_write(id_t id, addr_t addr, data_t data, strb_t strb,
                               int aw_lag, int w_lag);
        bit aw_hit;
        bit w_hit;
        bit aw_done = 1'b0;
        bit w_done  = 1'b0;
        int waited  = 0;
        while (exp_r.size() != 0)
            next_cycle();
        exp_b.push_back(ref_write(id, addr, data, strb));
        awid   = id;
        awaddr = addr;
        wdata  = data;
        wstrb  = strb;
        while (!(aw_done && w_done))
        begin
            if (!aw_done && waited >= aw_lag)
                awvalid = 1'b1;
            if (!w_done && waited >= w_lag)
                wvalid = 1'b1;
            @(negedge clk);
            aw_hit = awvalid && awready;
            w_hit  = wvalid && wready;
            next_cycle();
            if (aw_hit)
            begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit)
            begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            waited++;
        end
    endtask

    task automatic issue_read(id_t id, addr_t addr);
        bit ar_hit = 1'b0;
        while (exp_b.size() != 0)
            next_cycle();
        exp_r.push_back(ref_read(id, addr));
        arid    = id;
        araddr  = addr;
        arvalid = 1'b1;
        while (!ar_hit)
        begin
            @(negedge clk);
            ar_hit = arvalid && arready;
            // Latency counts from the cycle in which ar transfers
            if (ar_hit && !first_ar_seen)
            begin
                first_ar_seen = 1'b1;
                ar_xfer_cycle = cycle_cnt;
            end
            next_cycle();
        end
        arvalid = 1'b0;
    endtask

    task automatic random_mix(int count);
        addr_t addr;
        int    lag_a;
        int    lag_b;
        for (int n = 0; n < count; n++)
        begin
            // Mostly the filled words, now and then past the end of memory
            if ($urandom_range(0, 7) == 0)
                addr = addr_t'(MEM_BYTES + $urandom_range(0, 16'hFFFF - MEM_BYTES));
            else
                addr = addr_t'(4 * $urandom_range(0, FILL_WORDS - 1) + $urandom_range(0, 3));
            lag_a = $urandom_range(0, 2);
            lag_b = lag_a + 1 + $urandom_range(0, 1);
            if ($urandom_range(0, 1) == 0)
                issue_read(id_t'($urandom_range(0, 15)), addr);
            else if ($urandom_range(0, 1) == 0)
                issue_write(id_t'($urandom_range(0, 15)), addr, $urandom,
                            strb_t'($urandom_range(0, 15)), lag_a, lag_b);
            else
                issue_write(id_t'($urandom_range(0, 15)), addr, $urandom,
                            strb_t'($urandom_range(0, 15)), lag_b, lag_a);
        end
    endtask

    initial
    begin
        void'($urandom(32'h8909c369));
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if ({awready, wready, arready, bvalid, rvalid} !== 5'b0)
            fail_run("Ready or valid outputs were not low right after reset");
        next_cycle();

        // Full words over the fill region, then read back
        for (int i = 0; i < FILL_WORDS; i++)
            issue_write(id_t'($urandom_range(0, 15)), addr_t'(4 * i), $urandom, '1, 0, 0);
        for (int i = 0; i < FILL_WORDS; i++)
            issue_read(id_t'($urandom_range(0, 15)), addr_t'(4 * i));

        // Partial strobes over the same words
        for (int i = 0; i < FILL_WORDS; i++)
            issue_write(id_t'($urandom_range(0, 15)), addr_t'(4 * i), $urandom,
                        strb_t'($urandom_range(0, 15)), 0, 1);
        for (int i = 0; i < FILL_WORDS; i++)
            issue_read(id_t'($urandom_range(0, 15)), addr_t'(4 * i));

        // Past the end, at addresses that alias the first words
        for (int i = 0; i < 8; i++)
            issue_write(id_t'($urandom_range(0, 15)), addr_t'(MEM_BYTES + 4 * i), $urandom,
                        '1, 1, 0);
        issue_write(id_t'($urandom_range(0, 15)), 16'hFFFC, $urandom, '1, 0, 0);
        for (int i = 0; i < 8; i++)
        begin
            issue_read(id_t'($urandom_range(0, 15)), addr_t'(4 * i));
            issue_read(id_t'($urandom_range(0, 15)), addr_t'(MEM_BYTES + 4 * i));
        end
        issue_read(id_t'($urandom_range(0, 15)), 16'hFFFC);

        random_mix(300);
        @(negedge clk);
        stall_on = 1'b1;
        next_cycle();
        random_mix(300);

        while (exp_b.size() != 0 || exp_r.size() != 0)
            next_cycle();
        repeat (10) next_cycle();
        if (!latency_checked)
            fail_run("The first read response was never seen");
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
